// File: files.f
rtl/clock_pkg.sv
rtl/time_if.sv
rtl/tick_gen.sv
rtl/time_counter.sv
rtl/clock_ctrl.sv
rtl/chime_ring.sv
rtl/seg_scan.sv
rtl/alarm_clock_top.sv
tb/tb_alarm_clock.sv

// File: rtl/alarm_clock_top.sv
`timescale 1ns/1ps

module alarm_clock_top #(
    parameter int CYCLES_PER_SEC = clock_pkg::CYCLES_PER_SEC_DEF
) (
    input  logic                          clk_group,
    input  logic                          rst_n,
    input  logic                          power,
    input  logic                          enable,
    input  logic                          timing_clock,
    input  logic [2:0]                    add_time,
    input  logic [2:0]                    sub_time,
    output logic                          alarm,
    output logic                          timing_clock_alarm,
    output logic [7:0]                    anodes,
    output logic [7:0]                    cnodes,
    output logic [clock_pkg::FIELD_W-1:0] sec,
    output logic [clock_pkg::FIELD_W-1:0] min,
    output logic [clock_pkg::FIELD_W-1:0] hour
);

    logic       sec_tick;
    logic       scan_tick;
    logic       main_count_en;
    logic       alarm_count_en;
    logic [2:0] main_inc;
    logic [2:0] main_dec;
    logic [2:0] alarm_inc;
    logic [2:0] alarm_dec;
    logic       disp_sel;
    logic       blank;
    logic       chime_trig;
    logic       alarm_trig;

    time_if main_t ();
    time_if alarm_t ();

    tick_gen #(
        .CYCLES_PER_SEC(CYCLES_PER_SEC)
    ) u_tick_gen (
        .clk_group(clk_group),
        .rst_n    (rst_n),
        .sec_tick (sec_tick),
        .scan_tick(scan_tick)
    );

    //////////////////////////////
    // Running time and alarm time

    time_counter u_main_cnt (
        .clk_group(clk_group),
        .rst_n    (rst_n),
        .count_en (main_count_en),
        .sec_tick (sec_tick),
        .adj_inc  (main_inc),
        .adj_dec  (main_dec),
        .t        (main_t)
    );

    time_counter u_alarm_cnt (
        .clk_group(clk_group),
        .rst_n    (rst_n),
        .count_en (alarm_count_en),
        .sec_tick (sec_tick),
        .adj_inc  (alarm_inc),
        .adj_dec  (alarm_dec),
        .t        (alarm_t)
    );

    clock_ctrl u_ctrl (
        .clk_group     (clk_group),
        .rst_n         (rst_n),
        .power         (power),
        .enable        (enable),
        .timing_clock  (timing_clock),
        .add_time      (add_time),
        .sub_time      (sub_time),
        .sec_tick      (sec_tick),
        .main_t        (main_t),
        .alarm_t       (alarm_t),
        .main_count_en (main_count_en),
        .alarm_count_en(alarm_count_en),
        .main_inc      (main_inc),
        .main_dec      (main_dec),
        .alarm_inc     (alarm_inc),
        .alarm_dec     (alarm_dec),
        .disp_sel      (disp_sel),
        .blank         (blank),
        .chime_trig    (chime_trig),
        .alarm_trig    (alarm_trig)
    );

    //////////////////////////////
    // Rings and display

    // Hourly chime
    chime_ring u_chime_ring (
        .clk_group(clk_group),
        .rst_n    (rst_n),
        .trig     (chime_trig),
        .sec_tick (sec_tick),
        .ring     (alarm)
    );

    chime_ring u_alarm_ring (
        .clk_group(clk_group),
        .rst_n    (rst_n),
        .trig     (alarm_trig),
        .sec_tick (sec_tick),
        .ring     (timing_clock_alarm)
    );

    seg_scan u_seg_scan (
        .clk_group(clk_group),
        .rst_n    (rst_n),
        .scan_tick(scan_tick),
        .blank    (blank),
        .disp_sel (disp_sel),
        .main_t   (main_t),
        .alarm_t  (alarm_t),
        .anodes   (anodes),
        .cnodes   (cnodes)
    );

    assign sec  = main_t.sec;
    assign min  = main_t.min;
    assign hour = main_t.hour;

endmodule

// File: rtl/chime_ring.sv
`timescale 1ns/1ps

module chime_ring (
    input  logic clk_group,
    input  logic rst_n,
    input  logic trig,
    input  logic sec_tick,
    output logic ring
);

    localparam int CNT_W = $clog2(clock_pkg::RING_SECS + 1);

    // Seconds of ringing still to go
    logic [CNT_W-1:0] secs_left;

    always_ff @(posedge clk_group) begin
        if (!rst_n) begin
            secs_left <= '0;
        end else if (trig) begin
            // Retrigger restarts the full ring
            secs_left <= CNT_W'(clock_pkg::RING_SECS);
        end else if (sec_tick && (secs_left != '0)) begin
            secs_left <= secs_left - 1'b1;
        end
    end

    assign ring = (secs_left != '0);

endmodule

// File: rtl/clock_ctrl.sv
`timescale 1ns/1ps

module clock_ctrl (
    input  logic       clk_group,
    input  logic       rst_n,
    input  logic       power,
    input  logic       enable,
    input  logic       timing_clock,
    input  logic [2:0] add_time,
    input  logic [2:0] sub_time,
    input  logic       sec_tick,
    time_if.sink       main_t,
    time_if.sink       alarm_t,
    output logic       main_count_en,
    output logic       alarm_count_en,
    output logic [2:0] main_inc,
    output logic [2:0] main_dec,
    output logic [2:0] alarm_inc,
    output logic [2:0] alarm_dec,
    output logic       disp_sel,
    output logic       blank,
    output logic       chime_trig,
    output logic       alarm_trig
);

    clock_pkg::ctrl_state_t state;
    clock_pkg::ctrl_state_t state_nxt;
    logic                   main_adj;
    logic                   alarm_adj;
    logic                   time_match;

    // Power wins over alarm setting, which wins over run
    always_comb begin
        if (!power) begin
            state_nxt = clock_pkg::CLK_OFF;
        end else if (timing_clock) begin
            state_nxt = clock_pkg::CLK_SET_ALARM;
        end else if (enable) begin
            state_nxt = clock_pkg::CLK_RUN;
        end else begin
            state_nxt = clock_pkg::CLK_HOLD;
        end
    end

    always_ff @(posedge clk_group) begin
        if (!rst_n) begin
            state <= clock_pkg::CLK_OFF;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////
    // Adjust routing and counting

    assign main_adj  = (state == clock_pkg::CLK_RUN) || (state == clock_pkg::CLK_HOLD);
    assign alarm_adj = (state == clock_pkg::CLK_SET_ALARM);

    assign main_inc  = main_adj ? add_time : 3'b000;
    assign main_dec  = main_adj ? sub_time : 3'b000;
    assign alarm_inc = alarm_adj ? add_time : 3'b000;
    assign alarm_dec = alarm_adj ? sub_time : 3'b000;

    assign main_count_en  = (state == clock_pkg::CLK_RUN);
    // The alarm set is a plain register set
    assign alarm_count_en = 1'b0;

    assign disp_sel = alarm_adj;
    assign blank    = (state == clock_pkg::CLK_OFF);

    //////////////////////////////
    // Chime and alarm triggers

    assign time_match = (main_t.sec == alarm_t.sec) && (main_t.min == alarm_t.min)
                        && (main_t.hour == alarm_t.hour);

    // Minute wrap at 59:59 is exactly the top of the hour
    assign chime_trig = main_t.wrap_min && main_count_en;
    assign alarm_trig = sec_tick && time_match && main_count_en;

endmodule

// File: rtl/clock_pkg.sv
package clock_pkg;

    // Width of one time field
    localparam int FIELD_W = 6;

    // Field ranges, a field runs 0 .. limit-1
    localparam logic [FIELD_W-1:0] SEC_LIMIT  = FIELD_W'(60);
    localparam logic [FIELD_W-1:0] MIN_LIMIT  = FIELD_W'(60);
    localparam logic [FIELD_W-1:0] HOUR_LIMIT = FIELD_W'(24);

    //////////////////////////////
    // Timing

    // 50 MHz board clock by default
    localparam int CYCLES_PER_SEC_DEF = 50_000_000;

    // Cycles spent on each display digit
    localparam int SCAN_DIV = 16;

    // Length of a chime or alarm ring in seconds
    localparam int RING_SECS = 4;

    typedef enum logic [1:0] {
        CLK_OFF       = 2'd0,
        CLK_HOLD      = 2'd1,
        CLK_RUN       = 2'd2,
        CLK_SET_ALARM = 2'd3
    } ctrl_state_t;

    //////////////////////////////
    // Display

    localparam logic [3:0] DIGIT_BLANK = 4'd10;
    localparam logic [7:0] SEG_OFF     = 8'hFF;

endpackage

// File: rtl/seg_scan.sv
`timescale 1ns/1ps

module seg_scan (
    input  logic       clk_group,
    input  logic       rst_n,
    input  logic       scan_tick,
    input  logic       blank,
    input  logic       disp_sel,
    time_if.sink       main_t,
    time_if.sink       alarm_t,
    output logic [7:0] anodes,
    output logic [7:0] cnodes
);

    logic [2:0]                    digit_idx;
    logic [clock_pkg::FIELD_W-1:0] show_sec;
    logic [clock_pkg::FIELD_W-1:0] show_min;
    logic [clock_pkg::FIELD_W-1:0] show_hour;
    logic [7:0]                    sec_bcd;
    logic [7:0]                    min_bcd;
    logic [7:0]                    hour_bcd;
    logic [3:0]                    digit;

    // Tens in the upper nibble, found by repeated subtraction of ten
    function automatic logic [7:0] to_bcd(input logic [clock_pkg::FIELD_W-1:0] v);
        logic [3:0]                    tens;
        logic [clock_pkg::FIELD_W-1:0] rest;
        tens = 4'd0;
        rest = v;
        for (int i = 0; i < 6; i++) begin
            if (rest >= clock_pkg::FIELD_W'(10)) begin
                rest = rest - clock_pkg::FIELD_W'(10);
                tens = tens + 4'd1;
            end
        end
        return {tens, rest[3:0]};
    endfunction

    // Segments {dp, g, f, e, d, c, b, a}, low is lit
    function automatic logic [7:0] seg_encode(input logic [3:0] d);
        logic [7:0] seg;
        case (d)
            4'd0:    seg = 8'hC0;
            4'd1:    seg = 8'hF9;
            4'd2:    seg = 8'hA4;
            4'd3:    seg = 8'hB0;
            4'd4:    seg = 8'h99;
            4'd5:    seg = 8'h92;
            4'd6:    seg = 8'h82;
            4'd7:    seg = 8'hF8;
            4'd8:    seg = 8'h80;
            4'd9:    seg = 8'h90;
            default: seg = clock_pkg::SEG_OFF;
        endcase
        return seg;
    endfunction

    assign show_sec  = disp_sel ? alarm_t.sec : main_t.sec;
    assign show_min  = disp_sel ? alarm_t.min : main_t.min;
    assign show_hour = disp_sel ? alarm_t.hour : main_t.hour;

    assign sec_bcd  = to_bcd(show_sec);
    assign min_bcd  = to_bcd(show_min);
    assign hour_bcd = to_bcd(show_hour);

    //////////////////////////////
    // Layout hh _ mm _ ss, digit 7 leftmost

    always_comb begin
        case (digit_idx)
            3'd7:    digit = hour_bcd[7:4];
            3'd6:    digit = hour_bcd[3:0];
            3'd4:    digit = min_bcd[7:4];
            3'd3:    digit = min_bcd[3:0];
            3'd1:    digit = sec_bcd[7:4];
            3'd0:    digit = sec_bcd[3:0];
            default: digit = clock_pkg::DIGIT_BLANK;
        endcase
    end

    always_ff @(posedge clk_group) begin
        if (!rst_n) begin
            digit_idx <= 3'd0;
        end else if (scan_tick) begin
            digit_idx <= digit_idx + 3'd1;
        end
    end

    always_ff @(posedge clk_group) begin
        if (!rst_n || blank) begin
            anodes <= 8'hFF;
            cnodes <= clock_pkg::SEG_OFF;
        end else begin
            anodes <= ~(8'b0000_0001 << digit_idx);
            cnodes <= seg_encode(digit);
        end
    end

endmodule

// File: rtl/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
    parameter int CYCLES_PER_SEC = clock_pkg::CYCLES_PER_SEC_DEF
) (
    input  logic clk_group,
    input  logic rst_n,
    output logic sec_tick,
    output logic scan_tick
);

    localparam int SEC_W  = $clog2(CYCLES_PER_SEC);
    localparam int SCAN_W = $clog2(clock_pkg::SCAN_DIV);

    logic [SEC_W-1:0]  sec_cnt;
    logic [SCAN_W-1:0] scan_cnt;

    // Both strobes fire on the last count of their period
    assign sec_tick  = (sec_cnt == SEC_W'(CYCLES_PER_SEC - 1));
    assign scan_tick = (scan_cnt == SCAN_W'(clock_pkg::SCAN_DIV - 1));

    always_ff @(posedge clk_group) begin
        if (!rst_n) begin
            sec_cnt  <= '0;
            scan_cnt <= '0;
        end else begin
            sec_cnt  <= sec_tick ? '0 : sec_cnt + 1'b1;
            scan_cnt <= scan_tick ? '0 : scan_cnt + 1'b1;
        end
    end

endmodule

// File: rtl/time_counter.sv
`timescale 1ns/1ps

module time_counter (
    input  logic       clk_group,
    input  logic       rst_n,
    input  logic       count_en,
    input  logic       sec_tick,
    input  logic [2:0] adj_inc,
    input  logic [2:0] adj_dec,
    time_if.src        t
);

    logic                          count_step;
    logic [clock_pkg::FIELD_W-1:0] sec_cnt;
    logic [clock_pkg::FIELD_W-1:0] min_cnt;
    logic [clock_pkg::FIELD_W-1:0] hour_cnt;

    // One step inside 0 .. limit-1, opposing requests cancel
    function automatic logic [clock_pkg::FIELD_W-1:0] step(
        input logic [clock_pkg::FIELD_W-1:0] v,
        input logic [clock_pkg::FIELD_W-1:0] limit,
        input logic                          up,
        input logic                          down
    );
        logic [clock_pkg::FIELD_W-1:0] r;
        r = v;
        if (up && !down) begin
            r = (v == limit - 1'b1) ? '0 : v + 1'b1;
        end else if (down && !up) begin
            r = (v == '0) ? limit - 1'b1 : v - 1'b1;
        end
        return r;
    endfunction

    assign count_step = count_en && sec_tick;

    //////////////////////////////
    // Cascade on the second strobe

    assign t.wrap_sec = count_step && (t.sec == clock_pkg::SEC_LIMIT - 1'b1);
    assign t.wrap_min = t.wrap_sec && (t.min == clock_pkg::MIN_LIMIT - 1'b1);

    always_comb begin
        sec_cnt  = step(t.sec, clock_pkg::SEC_LIMIT, count_step, 1'b0);
        min_cnt  = step(t.min, clock_pkg::MIN_LIMIT, t.wrap_sec, 1'b0);
        hour_cnt = step(t.hour, clock_pkg::HOUR_LIMIT, t.wrap_min, 1'b0);
    end

    //////////////////////////////
    // Adjust goes on top of the count, no carry between fields

    always_ff @(posedge clk_group) begin
        if (!rst_n) begin
            t.sec  <= '0;
            t.min  <= '0;
            t.hour <= '0;
        end else begin
            t.sec  <= step(sec_cnt, clock_pkg::SEC_LIMIT, adj_inc[0], adj_dec[0]);
            t.min  <= step(min_cnt, clock_pkg::MIN_LIMIT, adj_inc[1], adj_dec[1]);
            t.hour <= step(hour_cnt, clock_pkg::HOUR_LIMIT, adj_inc[2], adj_dec[2]);
        end
    end

endmodule

// File: rtl/time_if.sv
`timescale 1ns/1ps

interface time_if;

    logic [clock_pkg::FIELD_W-1:0] sec;
    logic [clock_pkg::FIELD_W-1:0] min;
    logic [clock_pkg::FIELD_W-1:0] hour;

    // One-cycle strobes, field at limit-1 and counting
    logic wrap_sec;
    logic wrap_min;

    modport src (
        output sec, min, hour, wrap_sec, wrap_min
    );

    modport sink (
        input sec, min, hour, wrap_sec, wrap_min
    );

endinterface

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_alarm_clock \
    --Mdir "$OBJ_DIR" -o tb_alarm_clock > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/tb_alarm_clock" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

// File: tb/tb_alarm_clock.sv
`timescale 1ns/1ps

module tb_alarm_clock;

    localparam int CPS         = 8;
    localparam int CLK_PERIOD  = 20;
    localparam int SEED        = 32'h21cd_2abe;
    localparam int SEC_LIM     = int'(clock_pkg::SEC_LIMIT);
    localparam int MIN_LIM     = int'(clock_pkg::MIN_LIMIT);
    localparam int HOUR_LIM    = int'(clock_pkg::HOUR_LIMIT);
    localparam int RING_CYCLES = clock_pkg::RING_SECS * CPS;
    localparam int SCAN_CYCLES = clock_pkg::SCAN_DIV * 8;

    localparam logic [2:0] SEL_SEC  = 3'b001;
    localparam logic [2:0] SEL_MIN  = 3'b010;
    localparam logic [2:0] SEL_HOUR = 3'b100;

    // Alarm time used in the match test
    localparam int ALARM_H = 10;
    localparam int ALARM_M = 20;
    localparam int ALARM_S = 30;

    // Cycle budget per test, random adjusts stay below twice the field limit
    localparam int BUDGET_1 = 3 * CPS + 4;
    localparam int BUDGET_2 = 10 * CPS + 150;
    localparam int BUDGET_3 = 4 * (SEC_LIM + MIN_LIM + HOUR_LIM) + 12;
    localparam int BUDGET_4 = 15 * CPS + 150;
    localparam int BUDGET_5 = 12 * CPS + 300 + SCAN_CYCLES;
    localparam int BUDGET_6 = SCAN_CYCLES + 150;
    localparam int WATCHDOG_CYCLES = BUDGET_1 + BUDGET_2 + BUDGET_3 + BUDGET_4
                                     + BUDGET_5 + BUDGET_6 + 200;

    logic                          clk_group;
    logic                          rst_n;
    logic                          power;
    logic                          enable;
    logic                          timing_clock;
    logic [2:0]                    add_time;
    logic [2:0]                    sub_time;
    logic                          alarm;
    logic                          timing_clock_alarm;
    logic [7:0]                    anodes;
    logic [7:0]                    cnodes;
    logic [clock_pkg::FIELD_W-1:0] sec;
    logic [clock_pkg::FIELD_W-1:0] min;
    logic [clock_pkg::FIELD_W-1:0] hour;

    int seed;
    int errors;
    int tests_run;
    int tests_failed;

    alarm_clock_top #(
        .CYCLES_PER_SEC(CPS)
    ) dut (
        .clk_group         (clk_group),
        .rst_n             (rst_n),
        .power             (power),
        .enable            (enable),
        .timing_clock      (timing_clock),
        .add_time          (add_time),
        .sub_time          (sub_time),
        .alarm             (alarm),
        .timing_clock_alarm(timing_clock_alarm),
        .anodes            (anodes),
        .cnodes            (cnodes),
        .sec               (sec),
        .min               (min),
        .hour              (hour)
    );

    always #(CLK_PERIOD / 2) clk_group = ~clk_group;

    //////////////////////////////
    // Reference model helpers

    function automatic int wrap_add(input int value, input int delta, input int limit);
        return ((value + delta) % limit + limit) % limit;
    endfunction

    // Increments that move a field from one value to another
    function automatic int wrap_steps(input int from, input int to, input int limit);
        return wrap_add(to, -from, limit);
    endfunction

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        r = r & 32'h7fff_ffff;
        return r % n;
    endfunction

    // Active-low segments {dp, g, f, e, d, c, b, a}
    function automatic int decode_seg(input logic [7:0] seg);
        int d;
        case (seg)
            8'hC0:              d = 0;
            8'hF9:              d = 1;
            8'hA4:              d = 2;
            8'hB0:              d = 3;
            8'h99:              d = 4;
            8'h92:              d = 5;
            8'h82:              d = 6;
            8'hF8:              d = 7;
            8'h80:              d = 8;
            8'h90:              d = 9;
            clock_pkg::SEG_OFF: d = int'(clock_pkg::DIGIT_BLANK);
            default:            d = 15;
        endcase
        return d;
    endfunction

    // hh _ mm _ ss with digit 7 on the left
    function automatic int digit_at(input int pos, input int h, input int m, input int s);
        int d;
        case (pos)
            7:       d = h / 10;
            6:       d = h % 10;
            4:       d = m / 10;
            3:       d = m % 10;
            1:       d = s / 10;
            0:       d = s % 10;
            default: d = int'(clock_pkg::DIGIT_BLANK);
        endcase
        return d;
    endfunction

    //////////////////////////////
    // Drive and check helpers

    task automatic check_val(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            $display("ERROR at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_time(input int h, input int m, input int s);
        check_val("hour", int'(hour), h);
        check_val("min", int'(min), m);
        check_val("sec", int'(sec), s);
    endtask

    // One edge loads the FSM state, counting can start on the next one
    task automatic set_mode(input bit pwr, input bit en, input bit set_alarm);
        power        = pwr;
        enable       = en;
        timing_clock = set_alarm;
        @(negedge clk_group);
    endtask

    task automatic pulse_adjust(input logic [2:0] field, input bit up, input int count);
        for (int i = 0; i < count; i++) begin
            if (up) begin
                add_time = field;
            end else begin
                sub_time = field;
            end
            @(negedge clk_group);
        end
        add_time = 3'b000;
        sub_time = 3'b000;
        @(negedge clk_group);
    endtask

    task automatic adjust_to(input int cur_h, input int cur_m, input int cur_s,
                             input int h, input int m, input int s);
        pulse_adjust(SEL_SEC, 1'b1, wrap_steps(cur_s, s, SEC_LIM));
        pulse_adjust(SEL_MIN, 1'b1, wrap_steps(cur_m, m, MIN_LIM));
        pulse_adjust(SEL_HOUR, 1'b1, wrap_steps(cur_h, h, HOUR_LIM));
    endtask

    task automatic adjust_random(input logic [2:0] field, input int limit, inout int value);
        int n_add;
        int n_sub;
        n_add = rand_below(2 * limit);
        n_sub = rand_below(2 * limit);
        pulse_adjust(field, 1'b1, n_add);
        pulse_adjust(field, 1'b0, n_sub);
        value = wrap_add(value, n_add - n_sub, limit);
    endtask

    task automatic wait_next_second();
        logic [clock_pkg::FIELD_W-1:0] last;
        int                            n;
        last = sec;
        n = 0;
        while (sec == last && n < CPS + 2) begin
            @(negedge clk_group);
            n++;
        end
        assert (sec != last) else begin
            $display("Seconds did not advance within %0d cycles", CPS + 2);
            errors++;
        end
    endtask

    // Cycles a ring output stays high, counted from its first high sample
    task automatic measure_ring(input bit use_alarm_ring, output int cycles);
        cycles = 0;
        while ((use_alarm_ring ? timing_clock_alarm : alarm) && cycles <= RING_CYCLES) begin
            @(negedge clk_group);
            cycles++;
        end
    endtask

    task automatic scan_display(input int h, input int m, input int s);
        bit [7:0] seen;
        int       pos;
        seen = 8'h00;
        repeat (SCAN_CYCLES) begin
            @(negedge clk_group);
            assert ($onehot(~anodes)) else begin
                $display("ERROR at %0t ns: anodes = %b, expected one low bit", $time, anodes);
                errors++;
            end
            pos = -1;
            for (int i = 0; i < 8; i++) begin
                if (anodes == ~(8'h01 << i)) begin
                    pos = i;
                end
            end
            if (pos >= 0) begin
                seen = seen | (8'h01 << pos);
                check_val($sformatf("cnodes digit %0d", pos), decode_seg(cnodes),
                          digit_at(pos, h, m, s));
            end
        end
        check_val("anodes positions seen", int'(seen), 255);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - errors_before);
        end
    endtask

    //////////////////////////////
    // Directed tests

    task automatic test_reset_power_off();
        int e0;
        e0 = errors;
        check_time(0, 0, 0);
        check_val("alarm", int'(alarm), 0);
        check_val("timing_clock_alarm", int'(timing_clock_alarm), 0);
        repeat (3 * CPS) begin
            @(negedge clk_group);
            check_val("anodes", int'(anodes), 255);
            check_val("cnodes", int'(cnodes), int'(clock_pkg::SEG_OFF));
        end
        check_time(0, 0, 0);
        report_test("Test 1 reset and power off", e0);
    endtask

    task automatic test_count_cascade();
        int e0;
        int start;
        e0 = errors;
        set_mode(1'b1, 1'b1, 1'b0);
        wait_next_second();
        start = int'(sec);
        for (int i = 1; i <= 3; i++) begin
            repeat (CPS) @(negedge clk_group);
            check_val("sec", int'(sec), wrap_add(start, i, SEC_LIM));
        end
        set_mode(1'b1, 1'b0, 1'b0);
        adjust_to(int'(hour), int'(min), int'(sec), 23, 59, 58);
        check_time(23, 59, 58);
        set_mode(1'b1, 1'b1, 1'b0);
        wait_next_second();
        check_time(23, 59, 59);
        wait_next_second();
        check_time(0, 0, 0);
        // Enable low must freeze the time
        set_mode(1'b1, 1'b0, 1'b0);
        start = int'(sec);
        repeat (3 * CPS) @(negedge clk_group);
        check_time(0, 0, start);
        report_test("Test 2 counting and cascade", e0);
    endtask

    task automatic test_adjust_wrap();
        int e0;
        int h;
        int m;
        int s;
        e0 = errors;
        set_mode(1'b1, 1'b0, 1'b0);
        h = int'(hour);
        m = int'(min);
        s = int'(sec);
        adjust_random(SEL_SEC, SEC_LIM, s);
        check_time(h, m, s);
        adjust_random(SEL_MIN, MIN_LIM, m);
        check_time(h, m, s);
        adjust_random(SEL_HOUR, HOUR_LIM, h);
        check_time(h, m, s);
        report_test("Test 3 adjust wrap without carry", e0);
    endtask

    task automatic test_hourly_chime();
        int e0;
        int n;
        e0 = errors;
        set_mode(1'b1, 1'b0, 1'b0);
        // Let an earlier chime run out
        repeat ((clock_pkg::RING_SECS + 1) * CPS) @(negedge clk_group);
        check_val("alarm", int'(alarm), 0);
        adjust_to(int'(hour), int'(min), int'(sec), 7, 59, 57);
        set_mode(1'b1, 1'b1, 1'b0);
        n = 0;
        while (!(int'(min) == 0 && int'(sec) == 0) && n < 4 * CPS) begin
            @(negedge clk_group);
            n++;
        end
        assert (int'(min) == 0 && int'(sec) == 0) else begin
            $display("Time never reached the top of the hour");
            errors++;
        end
        check_val("hour", int'(hour), 8);
        check_val("alarm", int'(alarm), 1);
        measure_ring(1'b0, n);
        check_val("alarm high cycles", n, RING_CYCLES);
        set_mode(1'b1, 1'b0, 1'b0);
        report_test("Test 4 hourly chime", e0);
    endtask

    task automatic test_alarm_match();
        int e0;
        int h;
        int m;
        int s;
        int n;
        e0 = errors;
        set_mode(1'b1, 1'b0, 1'b1);
        h = int'(hour);
        m = int'(min);
        s = int'(sec);
        // Alarm set still holds its reset value
        adjust_to(0, 0, 0, ALARM_H, ALARM_M, ALARM_S);
        check_time(h, m, s);
        scan_display(ALARM_H, ALARM_M, ALARM_S);
        check_time(h, m, s);
        set_mode(1'b1, 1'b0, 1'b0);
        adjust_to(h, m, s, ALARM_H, ALARM_M, ALARM_S - 1);
        check_val("timing_clock_alarm", int'(timing_clock_alarm), 0);
        set_mode(1'b1, 1'b1, 1'b0);
        n = 0;
        while (!timing_clock_alarm && n < 3 * CPS) begin
            @(negedge clk_group);
            n++;
        end
        assert (timing_clock_alarm) else begin
            $display("Alarm ring never started after the match");
            errors++;
        end
        measure_ring(1'b1, n);
        check_val("timing_clock_alarm high cycles", n, RING_CYCLES);
        repeat (3 * CPS) begin
            @(negedge clk_group);
            check_val("timing_clock_alarm", int'(timing_clock_alarm), 0);
        end
        set_mode(1'b1, 1'b0, 1'b0);
        report_test("Test 5 alarm match", e0);
    endtask

    task automatic test_display_scan();
        int e0;
        e0 = errors;
        set_mode(1'b1, 1'b0, 1'b0);
        // Known main time so the digits come from the test itself
        adjust_to(int'(hour), int'(min), int'(sec), 12, 34, 56);
        check_time(12, 34, 56);
        scan_display(12, 34, 56);
        report_test("Test 6 display scan", e0);
    endtask

    //////////////////////////////
    // Sequence and watchdog

    initial begin
        clk_group    = 1'b0;
        rst_n        = 1'b0;
        power        = 1'b0;
        enable       = 1'b0;
        timing_clock = 1'b0;
        add_time     = 3'b000;
        sub_time     = 3'b000;
        seed         = SEED;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (2) @(negedge clk_group);
        rst_n = 1'b1;
        test_reset_power_off();
        test_count_cascade();
        test_adjust_wrap();
        test_hourly_chime();
        test_alarm_match();
        test_display_scan();
        $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule
